// File: source/wb_mem_pkg.sv
package wb_mem_pkg;

    // Address region that a bus access falls in.
    typedef enum logic [1:0] {
        REGION_MEM  = 2'd0, // Word-wide RAM.
        REGION_SYS  = 2'd1, // Identification and scratch registers.
        REGION_NONE = 2'd2  // Nothing mapped here.
    } wb_region_e;

    // Acknowledge state of the memory slave.
    // A write goes from idle straight to done. A read waits one extra
    // cycle for the registered RAM output.
    typedef enum logic [1:0] {
        ACK_IDLE      = 2'd0,
        ACK_READ_WAIT = 2'd1,
        ACK_DONE      = 2'd2
    } mem_ack_state_e;

    // Values of address bits 31 to 28 for each mapped region.
    localparam logic [3:0] REGION_MEM_CODE = 4'h0;
    localparam logic [3:0] REGION_SYS_CODE = 4'h1;

    // Fixed word returned by the identification register.
    localparam logic [31:0] SYS_ID_VALUE = 32'h5742_4d31;

endpackage

// File: source/wb_bus_if.sv
// Slave side of a Wishbone classic bus, as seen after address decoding.
// The strobe carried here is already qualified with cyc.
interface wb_bus_if;

    logic [31:0] adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic        we;
    logic        stb;

    logic        ack;
    logic [31:0] dat_r;

    // The decoder drives the request side.
    modport master (
        output adr,
        output dat_w,
        output sel,
        output we,
        output stb,
        input  ack,
        input  dat_r
    );

    // Each slave answers with ack and read data.
    modport slave (
        input  adr,
        input  dat_w,
        input  sel,
        input  we,
        input  stb,
        output ack,
        output dat_r
    );

endinterface

// File: source/soc_mem.sv
module soc_mem #(
    parameter int MEM_WORDS = 256,
    localparam int ADR_WIDTH = $clog2(MEM_WORDS)
) (
    input  logic                 wb_clk_i,
    input  logic                 ena_i,
    input  logic [3:0]           wen_i,
    input  logic [ADR_WIDTH-1:0] addr_i,
    input  logic [31:0]          wdata_i,
    output logic [31:0]          rdata_o
);

    logic [31:0] mem [MEM_WORDS];

    // One port. A write cycle returns the word as it was before the write.
    always_ff @(posedge wb_clk_i) begin
        if (ena_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wen_i[b]) begin
                    mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
            rdata_o <= mem[addr_i]; // Holds while the RAM is not enabled.
        end
    end

endmodule

// File: source/mem_wb.sv
module mem_wb import wb_mem_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic     wb_clk_i,
    input  logic     reset_i,
    wb_bus_if.slave  bus
);

    localparam int ADR_WIDTH = $clog2(MEM_WORDS);

    mem_ack_state_e ack_state;
    logic           ram_ena;
    logic [3:0]     wen;

    // Once the ack is out the RAM is left alone, so a strobe that is still
    // high on the closing edge neither writes again nor changes the read data.
    assign ram_ena = bus.stb && (ack_state != ACK_DONE);

    assign wen = bus.sel & {4{bus.we && ram_ena}}; // Byte write enables.

    // Writes finish on the first edge, reads need the RAM register first.
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_state <= ACK_IDLE;
        end else begin
            case (ack_state)
                ACK_IDLE: begin
                    if (bus.stb) begin
                        ack_state <= bus.we ? ACK_DONE : ACK_READ_WAIT;
                    end
                end
                ACK_READ_WAIT: begin
                    // A master that gives up early gets no acknowledge.
                    ack_state <= bus.stb ? ACK_DONE : ACK_IDLE;
                end
                default: begin
                    ack_state <= ACK_IDLE; // Ack lasts exactly one cycle.
                end
            endcase
        end
    end

    assign bus.ack = (ack_state == ACK_DONE);

    soc_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) i_soc_mem (
        .wb_clk_i  (wb_clk_i),
        .ena_i     (ram_ena),
        .wen_i     (wen),
        .addr_i    (bus.adr[ADR_WIDTH+1:2]),
        .wdata_i   (bus.dat_w),
        .rdata_o   (bus.dat_r)
    );

endmodule

// File: source/wb_sysregs.sv
module wb_sysregs import wb_mem_pkg::*; (
    input  logic     wb_clk_i,
    input  logic     reset_i,
    wb_bus_if.slave  bus
);

    logic        ack;
    logic        access;
    logic        sel_id;
    logic        sel_scratch;
    logic [31:0] scratch;
    logic [31:0] rdata;

    // A strobe is taken once; the cycle with ack high is ignored.
    assign access = bus.stb && !ack;

    // Word index within the region, from address bits 27 to 2.
    assign sel_id      = (bus.adr[27:2] == 26'd0);
    assign sel_scratch = (bus.adr[27:2] == 26'd1);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack     <= 1'b0;
            scratch <= 32'h0;
        end else begin
            ack <= access;
            if (access && bus.we && sel_scratch) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.sel[b]) begin
                        scratch[b*8 +: 8] <= bus.dat_w[b*8 +: 8];
                    end
                end
            end
        end
    end

    // Read data is registered alongside the ack.
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (sel_id) begin
                rdata <= SYS_ID_VALUE; // Writes to this word have no effect.
            end else if (sel_scratch) begin
                rdata <= scratch;
            end else begin
                rdata <= 32'h0;
            end
        end
    end

    assign bus.ack   = ack;
    assign bus.dat_r = rdata;

endmodule

// File: source/wb_decoder.sv
module wb_decoder import wb_mem_pkg::*; (
    input  logic         wb_clk_i,
    input  logic         reset_i,

    input  logic [31:0]  wb_adr_i,
    input  logic [31:0]  wb_dat_i,
    input  logic [3:0]   wb_sel_i,
    input  logic         wb_we_i,
    input  logic         wb_cyc_i,
    input  logic         wb_stb_i,

    output logic         wb_ack_o,
    output logic [31:0]  wb_dat_o,

    wb_bus_if.master     mem_bus,
    wb_bus_if.master     sys_bus
);

    logic       valid;
    wb_region_e region;
    logic       none_ack; // Local acknowledge for unmapped space.

    assign valid = wb_cyc_i & wb_stb_i;

    always_comb begin
        if (wb_adr_i[31:28] == REGION_MEM_CODE) begin
            region = REGION_MEM;
        end else if (wb_adr_i[31:28] == REGION_SYS_CODE) begin
            region = REGION_SYS;
        end else begin
            region = REGION_NONE;
        end
    end

    // Both slaves see the same request; only the strobe is steered.
    assign mem_bus.adr   = wb_adr_i;
    assign mem_bus.dat_w = wb_dat_i;
    assign mem_bus.sel   = wb_sel_i;
    assign mem_bus.we    = wb_we_i;
    assign mem_bus.stb   = valid && (region == REGION_MEM);

    assign sys_bus.adr   = wb_adr_i;
    assign sys_bus.dat_w = wb_dat_i;
    assign sys_bus.sel   = wb_sel_i;
    assign sys_bus.we    = wb_we_i;
    assign sys_bus.stb   = valid && (region == REGION_SYS);

    // An unmapped access is answered after one cycle so the master never stalls.
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= valid && (region == REGION_NONE) && !none_ack;
        end
    end

    always_comb begin
        case (region)
            REGION_MEM: begin
                wb_ack_o = mem_bus.ack;
                wb_dat_o = mem_bus.dat_r;
            end
            REGION_SYS: begin
                wb_ack_o = sys_bus.ack;
                wb_dat_o = sys_bus.dat_r;
            end
            default: begin
                wb_ack_o = none_ack;
                wb_dat_o = 32'h0; // Unmapped reads return zero.
            end
        endcase
    end

endmodule

// File: source/wb_mem_top.sv
module wb_mem_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic         wb_clk_i,
    input  logic         reset_i,

    input  logic [31:0]  wb_adr_i,
    input  logic [31:0]  wb_dat_i,
    input  logic [3:0]   wb_sel_i,
    input  logic         wb_we_i,
    input  logic         wb_cyc_i,
    input  logic         wb_stb_i,

    output logic         wb_ack_o,
    output logic [31:0]  wb_dat_o
);

    // One bus per slave, both driven by the decoder.
    wb_bus_if mem_bus ();
    wb_bus_if sys_bus ();

    wb_decoder i_decoder (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_we_i   (wb_we_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_ack_o  (wb_ack_o),
        .wb_dat_o  (wb_dat_o),
        .mem_bus   (mem_bus.master),
        .sys_bus   (sys_bus.master)
    );

    mem_wb #(
        .MEM_WORDS (MEM_WORDS)
    ) i_mem_wb (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .bus       (mem_bus.slave)
    );

    wb_sysregs i_sysregs (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .bus       (sys_bus.slave)
    );

endmodule

// File: test/wb_mem_properties.sv
module wb_mem_properties import wb_mem_pkg::*; (
    input logic           wb_clk_i,
    input logic           reset_i,
    input logic           cyc_i,
    input logic           stb_i,
    input logic           ack_i,
    input mem_ack_state_e ack_state_i
);

    int failures = 0; // Number of assertion failures so far.

    // Ack is a single-cycle pulse.
    ack_single_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        ack_i |=> !ack_i)
        else begin
            failures++;
            $error("Ack stayed high for two cycles.");
        end

    ack_needs_strobe: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        ack_i |-> (cyc_i && stb_i))
        else begin
            failures++;
            $error("Ack without an active strobe.");
        end

    // When the master drops its strobe after the ack, the memory slave is idle again.
    mem_state_back_to_idle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        $fell(cyc_i && stb_i) |-> (ack_state_i == ACK_IDLE))
        else begin
            failures++;
            $error("Memory ack state did not return to idle.");
        end

endmodule

bind wb_mem_top wb_mem_properties i_properties (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .cyc_i       (wb_cyc_i),
    .stb_i       (wb_stb_i),
    .ack_i       (wb_ack_o),
    .ack_state_i (i_mem_wb.ack_state)
);

// File: test/wb_mem_checker.sv
module wb_mem_checker (
    input logic        wb_clk_i,
    input logic        reset_i,
    input logic        cyc_i,
    input logic        stb_i,
    input logic        ack_i,
    input logic [31:0] dat_i
);

    localparam int ACK_TIMEOUT = 10;

    // Written only by begin_test, on behalf of the stimulus.
    string       test_name;
    logic [31:0] exp_data;
    logic        check_data;
    int          exp_cycles;

    // Written only by the monitor below.
    logic        armed      = 1'b0;
    int          waited     = 0;
    int          stb_cycles = 0; // Edges with the strobe up and no ack yet.
    int          pass_count = 0;
    int          fail_count = 0;

    task begin_test(input string name, input logic [31:0] expected,
                    input logic data_valid, input int cycles);
        test_name  = name;
        exp_data   = expected;
        check_data = data_valid;
        exp_cycles = cycles;
    endtask

    always @(posedge wb_clk_i) begin
        if (armed) begin
            if (ack_i) begin
                if (check_data && dat_i !== exp_data) begin
                    $display("Fail %s: expected %08h, actual %08h", test_name, exp_data, dat_i);
                    fail_count++;
                end else if (stb_cycles != exp_cycles) begin
                    $display("Fail %s: expected ack after %0d cycles, actual %0d",
                             test_name, exp_cycles, stb_cycles);
                    fail_count++;
                end else begin
                    $display("Pass %s", test_name);
                    pass_count++;
                end
                armed = 1'b0;
            end else begin
                waited++;
                if (waited == ACK_TIMEOUT) begin
                    $display("%s: no acknowledge within timeout", test_name);
                    fail_count++;
                    armed = 1'b0;
                end
            end
        end else if (ack_i && !reset_i) begin
            $display("Acknowledge seen while no access was in progress");
            fail_count++;
        end else if (cyc_i && stb_i && stb_cycles == 0 && !reset_i) begin
            armed  = 1'b1; // First edge of a new strobe.
            waited = 0;
        end
        if (reset_i || !(cyc_i && stb_i)) begin
            stb_cycles = 0;
        end else if (!ack_i) begin
            stb_cycles++;
        end
    end

endmodule

// File: test/wb_mem_tb.sv
module wb_mem_tb;

    localparam int          MEM_WORDS   = 256;
    localparam int          ACK_TIMEOUT = 10;
    localparam logic [31:0] ID_WORD     = 32'h5742_4d31;
    localparam logic [31:0] SEED        = 32'hc771_eab7;

    // One bus access and the word it should return.
    typedef struct packed {
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] data;
        logic [31:0] expected;
    } access_t;

    logic        wb_clk;
    logic        reset;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_ack;
    logic [31:0] wb_dat_r;

    string   names[$];
    access_t accesses[$];

    wb_mem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) i_dut (
        .wb_clk_i  (wb_clk),
        .reset_i   (reset),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_dat_w),
        .wb_sel_i  (wb_sel),
        .wb_we_i   (wb_we),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_ack_o  (wb_ack),
        .wb_dat_o  (wb_dat_r)
    );

    wb_mem_checker i_checker (
        .wb_clk_i  (wb_clk),
        .reset_i   (reset),
        .cyc_i     (wb_cyc),
        .stb_i     (wb_stb),
        .ack_i     (wb_ack),
        .dat_i     (wb_dat_r)
    );

    initial begin
        wb_clk = 1'b0;
        forever #10 wb_clk = ~wb_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Bytes whose select bit is set come from the new word.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic add_test(input string name, input logic we, input logic [31:0] adr,
                            input logic [3:0] sel, input logic [31:0] data,
                            input logic [31:0] expected);
        access_t entry;
        entry.we       = we;
        entry.adr      = adr;
        entry.sel      = sel;
        entry.data     = data;
        entry.expected = expected;
        names.push_back(name);
        accesses.push_back(entry);
    endtask

    task automatic build_table();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] merged;
        logic [31:0] last_adr;
        r0       = xorshift32(SEED);
        r1       = xorshift32(r0);
        r2       = xorshift32(r1);
        merged   = merge_bytes(32'h1122_3344, 32'h0000_00a5, 4'b0001);
        merged   = merge_bytes(merged, 32'h00c3_0000, 4'b0100);
        last_adr = 32'((MEM_WORDS - 1) * 4);
        //       name                  we    adr           sel      data           expected
        add_test("word_write",         1'b1, 32'h0000_0004, 4'hf,   32'hdead_beef, 32'h0);
        add_test("word_read",          1'b0, 32'h0000_0004, 4'hf,   32'h0,         32'hdead_beef);
        add_test("merge_base_write",   1'b1, 32'h0000_0010, 4'hf,   32'h1122_3344, 32'h0);
        add_test("merge_byte0_write",  1'b1, 32'h0000_0010, 4'b0001, 32'h0000_00a5, 32'h0);
        add_test("merge_byte2_write",  1'b1, 32'h0000_0010, 4'b0100, 32'h00c3_0000, 32'h0);
        add_test("merge_read",         1'b0, 32'h0000_0010, 4'hf,   32'h0,         merged);
        add_test("spread_write_a",     1'b1, 32'h0000_0020, 4'hf,   r0,            32'h0);
        add_test("spread_write_b",     1'b1, 32'h0000_0024, 4'hf,   r1,            32'h0);
        add_test("last_word_write",    1'b1, last_adr,      4'hf,   r2,            32'h0);
        add_test("spread_read_a",      1'b0, 32'h0000_0020, 4'hf,   32'h0,         r0);
        add_test("spread_read_b",      1'b0, 32'h0000_0024, 4'hf,   32'h0,         r1);
        add_test("last_word_read",     1'b0, last_adr,      4'hf,   32'h0,         r2);
        add_test("id_read",            1'b0, 32'h1000_0000, 4'hf,   32'h0,         ID_WORD);
        add_test("id_write",           1'b1, 32'h1000_0000, 4'hf,   32'hffff_ffff, 32'h0);
        add_test("id_read_again",      1'b0, 32'h1000_0000, 4'hf,   32'h0,         ID_WORD);
        add_test("scratch_write",      1'b1, 32'h1000_0004, 4'b0010, 32'h1234_5a78, 32'h0);
        add_test("scratch_read",       1'b0, 32'h1000_0004, 4'hf,   32'h0,
                 merge_bytes(32'h0, 32'h1234_5a78, 4'b0010));
        add_test("unmapped_read",      1'b0, 32'h2000_0040, 4'hf,   32'h0,         32'h0);
    endtask

    task automatic run_test(input int idx);
        access_t entry;
        int      waited;
        int      cycles;
        entry  = accesses[idx];
        cycles = (entry.adr[31:28] == 4'h0 && !entry.we) ? 2 : 1; // RAM reads take two.
        @(posedge wb_clk);
        i_checker.begin_test(names[idx], entry.expected, !entry.we, cycles);
        wb_adr   <= entry.adr;
        wb_dat_w <= entry.data;
        wb_sel   <= entry.sel;
        wb_we    <= entry.we;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        waited = 0;
        do begin
            @(posedge wb_clk);
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge wb_clk); // Idle cycle between transfers.
    endtask

    initial begin
        int n;
        reset    = 1'b1;
        wb_adr   = 32'h0;
        wb_dat_w = 32'h0;
        wb_sel   = 4'h0;
        wb_we    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        build_table();
        repeat (4) @(posedge wb_clk);
        reset <= 1'b0;
        for (int i = 0; i < accesses.size(); i++) begin
            run_test(i);
        end
        n = 0;
        while (i_checker.armed && n < ACK_TIMEOUT + 2) begin
            @(posedge wb_clk);
            n++;
        end
        $display("%0d tests: %0d passed, %0d failed, %0d assertion failures", accesses.size(),
                 i_checker.pass_count, i_checker.fail_count, i_dut.i_properties.failures);
        if (i_checker.fail_count == 0 && i_checker.pass_count == accesses.size()
                && i_dut.i_properties.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/wb_mem_pkg.sv
source/wb_bus_if.sv
source/soc_mem.sv
source/mem_wb.sv
source/wb_sysregs.sv
source/wb_decoder.sv
source/wb_mem_top.sv
test/wb_mem_properties.sv
test/wb_mem_checker.sv
test/wb_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module wb_mem_tb -f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vwb_mem_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
